//--- hw/mega99_kbd_pkg.sv
package mega99_kbd_pkg;

   localparam int NUM_KEYS     = 48;
   localparam int FILTER_LEN   = 24;
   localparam int FILTER_CNT_W = $clog2(FILTER_LEN);

   localparam logic [7:0] SC_BREAK    = 8'hF0;
   localparam logic [7:0] SC_EXTENDED = 8'hE0;
   localparam logic [7:0] SC_CAPS     = 8'h58;   // Toggles alpha lock.
   localparam logic [7:0] SC_SCROLL   = 8'h7E;   // Toggles turbo.

   localparam logic [5:0] NO_KEY = 6'd63;

   typedef enum logic [1:0] {
      IDLE,
      DATA,
      PARITY,
      STOP
   } rx_state_e;

   // Set 2 make codes, position in the list is the key index.
   localparam logic [7:0] KEY_CODES [NUM_KEYS] = '{
      8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E,   // 1 to 8.
      8'h46, 8'h45, 8'h15, 8'h1D, 8'h24, 8'h2D, 8'h2C, 8'h35,   // 9, 0, Q to Y.
      8'h3C, 8'h43, 8'h44, 8'h4D, 8'h1C, 8'h1B, 8'h23, 8'h2B,   // U to P, A to F.
      8'h34, 8'h33, 8'h3B, 8'h42, 8'h4B, 8'h1A, 8'h22, 8'h21,   // G to L, Z to C.
      8'h2A, 8'h32, 8'h31, 8'h3A, 8'h55, 8'h4A, 8'h4C, 8'h5A,   // V to M, = / ; enter.
      8'h41, 8'h49, 8'h29, 8'h12, 8'h59, 8'h14, 8'h11, 8'h4E    // , . space shift ctrl fctn -.
   };

   function automatic logic [5:0] key_index_of(input logic [7:0] code);
      logic [5:0] idx;
      idx = NO_KEY;
      for (int i = 0; i < NUM_KEYS; i++) begin
         if (KEY_CODES[i] == code) begin
            idx = 6'(i);
         end
      end
      return idx;
   endfunction

endpackage

//--- hw/mega99_regs_pkg.sv
package mega99_regs_pkg;

   localparam int APB_AW = 8;
   localparam int APB_DW = 32;

   typedef enum logic [APB_AW-1:0] {
      REG_CTRL    = 8'h00,
      REG_STATUS  = 8'h04,
      REG_KEYS_LO = 8'h08,
      REG_KEYS_HI = 8'h0C,
      REG_AUDIO   = 8'h10
   } reg_addr_e;

   // CTRL fields.
   localparam int CTRL_EN_BIT  = 0;
   localparam int CTRL_CLR_BIT = 1;   // Write-only strobe.

   // STATUS fields.
   localparam int STAT_ALPHA_BIT = 0;
   localparam int STAT_TURBO_BIT = 1;
   localparam int STAT_ERR_BIT   = 2;   // Sticky, write 1 to clear.
   localparam int STAT_CODE_LSB  = 8;
   localparam int STAT_CODE_MSB  = 15;

   localparam int AUDIO_W = 16;

endpackage

//--- hw/ps2_receiver.sv
`timescale 1ns/1ps

module ps2_receiver (
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  logic       ps2_clk_i,
   input  logic       ps2_data_i,
   output logic [7:0] rx_byte_o,
   output logic       rx_valid_o,
   output logic       rx_error_o
);

   import mega99_kbd_pkg::*;

   logic [1:0]              clk_sync_q;
   logic [1:0]              dat_sync_q;
   logic                    clk_filt_q;
   logic [FILTER_CNT_W-1:0] filt_cnt_q;
   logic                    filt_done;
   logic                    fall;

   rx_state_e  state_q;
   logic [2:0] bit_cnt_q;
   logic [7:0] shift_q;
   logic       start_ok_q;
   logic       par_ok_q;
   logic       dat;

   assign dat       = dat_sync_q[1];
   assign filt_done = (filt_cnt_q == FILTER_CNT_W'(FILTER_LEN - 1));
   // Filtered clock is about to drop from high to low.
   assign fall      = clk_filt_q && !clk_sync_q[1] && filt_done;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         clk_sync_q <= '0;
         dat_sync_q <= '0;
         clk_filt_q <= 1'b0;
         filt_cnt_q <= '0;
      end else begin
         clk_sync_q <= {clk_sync_q[0], ps2_clk_i};
         dat_sync_q <= {dat_sync_q[0], ps2_data_i};
         if (clk_sync_q[1] == clk_filt_q) begin
            filt_cnt_q <= '0;                      // Glitch, start over.
         end else if (filt_done) begin
            clk_filt_q <= clk_sync_q[1];
            filt_cnt_q <= '0;
         end else begin
            filt_cnt_q <= filt_cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= IDLE;
         bit_cnt_q  <= '0;
         shift_q    <= '0;
         start_ok_q <= 1'b0;
         par_ok_q   <= 1'b0;
         rx_byte_o  <= '0;
         rx_valid_o <= 1'b0;
         rx_error_o <= 1'b0;
      end else begin
         rx_valid_o <= 1'b0;
         rx_error_o <= 1'b0;
         if (fall) begin
            case (state_q)
               IDLE: begin
                  start_ok_q <= !dat;
                  bit_cnt_q  <= '0;
                  state_q    <= DATA;
               end
               DATA: begin
                  shift_q   <= {dat, shift_q[7:1]};    // LSB first.
                  bit_cnt_q <= bit_cnt_q + 1'b1;
                  if (bit_cnt_q == 3'd7) begin
                     state_q <= PARITY;
                  end
               end
               PARITY: begin
                  par_ok_q <= ^{shift_q, dat};        // Odd parity.
                  state_q  <= STOP;
               end
               STOP: begin
                  state_q <= IDLE;
                  if (start_ok_q && par_ok_q && dat) begin
                     rx_byte_o  <= shift_q;
                     rx_valid_o <= 1'b1;
                  end else begin
                     rx_error_o <= 1'b1;
                  end
               end
            endcase
         end
      end
   end

endmodule

//--- hw/keyboard_matrix.sv
`timescale 1ns/1ps

module keyboard_matrix (
   input  logic                                clk_i,
   input  logic                                arst_n_i,
   input  logic [7:0]                          rx_byte_i,
   input  logic                                rx_valid_i,
   input  logic                                kbd_enable_i,
   input  logic                                keys_clear_i,
   output logic [mega99_kbd_pkg::NUM_KEYS-1:0] key_state_o,
   output logic                                alpha_state_o,
   output logic                                turbo_state_o,
   output logic [7:0]                          last_code_o
);

   import mega99_kbd_pkg::*;

   logic       brk_q;
   logic       ext_q;
   logic [5:0] key_idx;
   logic       byte_en;
   logic       is_prefix;

   assign key_idx   = key_index_of(rx_byte_i);
   assign byte_en   = rx_valid_i && kbd_enable_i;   // Dropped while disabled.
   assign is_prefix = (rx_byte_i == SC_BREAK) || (rx_byte_i == SC_EXTENDED);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         brk_q         <= 1'b0;
         ext_q         <= 1'b0;
         key_state_o   <= '0;
         alpha_state_o <= 1'b0;
         turbo_state_o <= 1'b0;
         last_code_o   <= '0;
      end else begin
         if (byte_en) begin
            if (rx_byte_i == SC_BREAK) begin
               brk_q <= 1'b1;
            end else if (rx_byte_i == SC_EXTENDED) begin
               ext_q <= 1'b1;
            end

            if (!is_prefix) begin
               brk_q       <= 1'b0;
               ext_q       <= 1'b0;
               last_code_o <= rx_byte_i;

               if (key_idx != NO_KEY) begin
                  key_state_o[key_idx] <= !brk_q;
               end

               // E0 7E is Ctrl+Break, not scroll lock.
               if (!brk_q && !ext_q) begin
                  if (rx_byte_i == SC_CAPS) begin
                     alpha_state_o <= !alpha_state_o;
                  end
                  if (rx_byte_i == SC_SCROLL) begin
                     turbo_state_o <= !turbo_state_o;
                  end
               end
            end
         end

         if (keys_clear_i) begin
            key_state_o <= '0;                 // Toggles are kept.
         end
      end
   end

endmodule

//--- hw/sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac (
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic [15:0] sample_i,
   output logic        audio_o
);

   logic [15:0] acc_q;
   logic [16:0] sum;

   assign sum = {1'b0, acc_q} + {1'b0, sample_i};

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         acc_q   <= '0;
         audio_o <= 1'b0;
      end else begin
         acc_q   <= sum[15:0];
         audio_o <= sum[16];   // Carry out is the bit stream.
      end
   end

endmodule

//--- hw/io_regs.sv
`timescale 1ns/1ps

module io_regs (
   input  logic                                clk_i,
   input  logic                                arst_n_i,
   input  logic [mega99_regs_pkg::APB_AW-1:0]  paddr_i,
   input  logic                                psel_i,
   input  logic                                penable_i,
   input  logic                                pwrite_i,
   input  logic [mega99_regs_pkg::APB_DW-1:0]  pwdata_i,
   output logic [mega99_regs_pkg::APB_DW-1:0]  prdata_o,
   output logic                                pready_o,
   output logic                                pslverr_o,
   input  logic [mega99_kbd_pkg::NUM_KEYS-1:0] key_state_i,
   input  logic                                alpha_state_i,
   input  logic                                turbo_state_i,
   input  logic [7:0]                          last_code_i,
   input  logic                                rx_error_i,
   output logic                                kbd_enable_o,
   output logic                                keys_clear_o,
   output logic [mega99_regs_pkg::AUDIO_W-1:0] audio_sample_o
);

   import mega99_kbd_pkg::*;
   import mega99_regs_pkg::*;

   logic [APB_DW-1:0] rdata;
   logic              mapped;
   logic              wr_en;
   logic              frame_err_q;
   reg_addr_e         addr;

   assign addr    = reg_addr_e'(paddr_i);
   assign wr_en   = psel_i && penable_i && pwrite_i && mapped;

   assign pready_o  = 1'b1;                           // No wait states.
   assign pslverr_o = psel_i && penable_i && !mapped;
   assign prdata_o  = rdata;

   always_comb begin
      rdata  = '0;
      mapped = 1'b1;
      case (addr)
         REG_CTRL: begin
            rdata[CTRL_EN_BIT] = kbd_enable_o;
         end
         REG_STATUS: begin
            rdata[STAT_ALPHA_BIT]               = alpha_state_i;
            rdata[STAT_TURBO_BIT]               = turbo_state_i;
            rdata[STAT_ERR_BIT]                 = frame_err_q;
            rdata[STAT_CODE_MSB:STAT_CODE_LSB]  = last_code_i;
         end
         REG_KEYS_LO: begin
            rdata = key_state_i[APB_DW-1:0];
         end
         REG_KEYS_HI: begin
            rdata = APB_DW'(key_state_i[NUM_KEYS-1:APB_DW]);
         end
         REG_AUDIO: begin
            rdata = APB_DW'(audio_sample_o);
         end
         default: begin
            mapped = 1'b0;                             // Reads back zero.
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         kbd_enable_o   <= 1'b0;
         keys_clear_o   <= 1'b0;
         frame_err_q    <= 1'b0;
         audio_sample_o <= '0;
      end else begin
         keys_clear_o <= 1'b0;

         if (wr_en && addr == REG_CTRL) begin
            kbd_enable_o <= pwdata_i[CTRL_EN_BIT];
            keys_clear_o <= pwdata_i[CTRL_CLR_BIT];
         end

         // A new error wins over a clear in the same cycle.
         if (rx_error_i) begin
            frame_err_q <= 1'b1;
         end else if (wr_en && addr == REG_STATUS && pwdata_i[STAT_ERR_BIT]) begin
            frame_err_q <= 1'b0;
         end

         if (wr_en && addr == REG_AUDIO) begin
            audio_sample_o <= pwdata_i[AUDIO_W-1:0];
         end
      end
   end

endmodule

//--- hw/mega99_io_top.sv
`timescale 1ns/1ps

module mega99_io_top (
   input  logic                               clk_i,
   input  logic                               arst_n_i,
   input  logic                               ps2_clk_i,
   input  logic                               ps2_data_i,
   input  logic [mega99_regs_pkg::APB_AW-1:0] paddr_i,
   input  logic                               psel_i,
   input  logic                               penable_i,
   input  logic                               pwrite_i,
   input  logic [mega99_regs_pkg::APB_DW-1:0] pwdata_i,
   output logic [mega99_regs_pkg::APB_DW-1:0] prdata_o,
   output logic                               pready_o,
   output logic                               pslverr_o,
   output logic                               audio_o
);

   import mega99_kbd_pkg::*;
   import mega99_regs_pkg::*;

   logic [7:0]          rx_byte;
   logic                rx_valid;
   logic                rx_error;
   logic [NUM_KEYS-1:0] key_state;
   logic                alpha_state;
   logic                turbo_state;
   logic [7:0]          last_code;
   logic                kbd_enable;
   logic                keys_clear;
   logic [AUDIO_W-1:0]  audio_sample;

   ps2_receiver ps2_receiver_i (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .ps2_clk_i(ps2_clk_i), .ps2_data_i(ps2_data_i),
      .rx_byte_o(rx_byte), .rx_valid_o(rx_valid), .rx_error_o(rx_error)
   );

   keyboard_matrix keyboard_matrix_i (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .rx_byte_i(rx_byte), .rx_valid_i(rx_valid),
      .kbd_enable_i(kbd_enable), .keys_clear_i(keys_clear),
      .key_state_o(key_state), .alpha_state_o(alpha_state),
      .turbo_state_o(turbo_state), .last_code_o(last_code)
   );

   sigma_delta_dac sigma_delta_dac_i (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .sample_i(audio_sample), .audio_o(audio_o)
   );

   io_regs io_regs_i (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i),
      .pwrite_i(pwrite_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
      .pready_o(pready_o), .pslverr_o(pslverr_o),
      .key_state_i(key_state), .alpha_state_i(alpha_state),
      .turbo_state_i(turbo_state), .last_code_i(last_code),
      .rx_error_i(rx_error),
      .kbd_enable_o(kbd_enable), .keys_clear_o(keys_clear),
      .audio_sample_o(audio_sample)
   );

endmodule

//--- testbench/mega99_io_props.sv
`timescale 1ns/1ps

module mega99_io_props (
   input logic                                clk_i,
   input logic                                arst_n_i,
   input logic [mega99_regs_pkg::APB_AW-1:0]  paddr_i,
   input logic                                psel_i,
   input logic                                penable_i,
   input logic                                pready_i,
   input logic                                pslverr_i,
   input logic                                keys_clear_i,
   input logic [mega99_kbd_pkg::NUM_KEYS-1:0] key_state_i
);

   import mega99_regs_pkg::*;

   int unsigned fail_cnt = 0;
   logic        mapped;

   assign mapped = (paddr_i == REG_CTRL) || (paddr_i == REG_STATUS) ||
                   (paddr_i == REG_KEYS_LO) || (paddr_i == REG_KEYS_HI) ||
                   (paddr_i == REG_AUDIO);

   pready_high: assert property (@(posedge clk_i) disable iff (!arst_n_i) pready_i)
      else begin
         $error("pready dropped low");
         fail_cnt = fail_cnt + 1;
      end

   slverr_only_unmapped: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      pslverr_i |-> (psel_i && penable_i && !mapped))
      else begin
         $error("pslverr outside an unmapped access phase");
         fail_cnt = fail_cnt + 1;
      end

   clear_empties_keys: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      keys_clear_i |=> (key_state_i == '0))
      else begin
         $error("key state not zero after keys_clear");
         fail_cnt = fail_cnt + 1;
      end

endmodule

bind io_regs mega99_io_props props_i (
   .clk_i(clk_i), .arst_n_i(arst_n_i), .paddr_i(paddr_i),
   .psel_i(psel_i), .penable_i(penable_i),
   .pready_i(pready_o), .pslverr_i(pslverr_o),
   .keys_clear_i(keys_clear_o), .key_state_i(key_state_i)
);

//--- testbench/mega99_io_tb.sv
`timescale 1ns/1ps

module mega99_io_tb;

   import mega99_kbd_pkg::*;

   localparam int PS2_HALF     = 50;                // Half of a 100-cycle PS/2 bit.
   localparam int KEY_ROUNDS   = 4;
   localparam int NUM_FRAMES   = KEY_ROUNDS * 3 + 6 + 2 + 2 + 1;
   localparam int WATCHDOG_CYC = NUM_FRAMES * 11 * 2 * PS2_HALF + 5000;

   logic        clk;
   logic        arst_n;
   logic        ps2_clk;
   logic        ps2_data;
   logic [7:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        audio;

   int          errors;
   int          idx;
   int          other;
   int          ones;
   logic [47:0] exp_keys;
   logic        exp_alpha;
   logic        exp_turbo;
   logic [7:0]  exp_code;
   logic [31:0] rd;
   logic        err;

   mega99_io_top mega99_io_top_i (
      .clk_i(clk), .arst_n_i(arst_n), .ps2_clk_i(ps2_clk), .ps2_data_i(ps2_data),
      .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
      .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
      .audio_o(audio)
   );

   always #5 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, act);
         errors++;
      end
   endtask

   // Start, 8 data bits LSB first, odd parity, stop.
   task automatic send_frame(input logic [7:0] code, input logic bad_parity);
      logic [10:0] bits;
      logic        par;
      par  = ~^code;
      bits = {1'b1, par ^ bad_parity, code, 1'b0};
      for (int b = 0; b < 11; b++) begin
         ps2_data = bits[b];
         repeat (PS2_HALF) @(negedge clk);
         ps2_clk = 1'b0;
         repeat (PS2_HALF) @(negedge clk);
         ps2_clk = 1'b1;
      end
      repeat (FILTER_LEN + 4) @(negedge clk);
   endtask

   task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic slverr);
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      #1;
      rdata  = prdata;                              // Sampled mid access phase.
      slverr = pslverr;
      check_value("apb pready", 32'h1, {31'h0, pready});
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic slverr);
      logic [31:0] unused;
      apb_access(addr, 1'b1, data, unused, slverr);
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic slverr);
      apb_access(addr, 1'b0, 32'h0, data, slverr);
   endtask

   task automatic read_check(input string name, input logic [7:0] addr, input logic [31:0] exp);
      logic [31:0] data;
      logic        slverr;
      apb_read(addr, data, slverr);
      check_value(name, exp, data);
      check_value({name, " pslverr"}, 32'h0, {31'h0, slverr});
   endtask

   task automatic check_keys(input string name);
      read_check({name, " lo"}, 8'h08, exp_keys[31:0]);
      read_check({name, " hi"}, 8'h0C, {16'h0, exp_keys[47:32]});
   endtask

   task automatic check_status(input string name, input logic exp_err);
      read_check(name, 8'h04, {16'h0, exp_code, 5'h0, exp_err, exp_turbo, exp_alpha});
   endtask

   initial begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      ps2_clk   = 1'b1;                             // PS/2 lines idle high.
      ps2_data  = 1'b1;
      paddr     = '0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      pwdata    = '0;
      errors    = 0;
      exp_keys  = '0;
      exp_alpha = 1'b0;
      exp_turbo = 1'b0;
      exp_code  = '0;
      void'($urandom(64));
      repeat (8) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      apb_write(8'h00, 32'h1, err);

      for (int r = 0; r < KEY_ROUNDS; r++) begin
         idx = int'($urandom % NUM_KEYS);
         send_frame(KEY_CODES[idx], 1'b0);
         exp_keys[idx] = 1'b1;
         exp_code      = KEY_CODES[idx];
         check_keys("key make");
         check_status("key make status", 1'b0);
         send_frame(SC_BREAK, 1'b0);
         send_frame(KEY_CODES[idx], 1'b0);
         exp_keys[idx] = 1'b0;
         check_keys("key break");
      end

      send_frame(SC_CAPS, 1'b0);
      exp_alpha = 1'b1;
      exp_code  = SC_CAPS;
      check_status("caps make", 1'b0);
      send_frame(SC_BREAK, 1'b0);
      send_frame(SC_CAPS, 1'b0);
      check_status("caps break", 1'b0);
      send_frame(SC_SCROLL, 1'b0);
      exp_turbo = 1'b1;
      exp_code  = SC_SCROLL;
      check_status("scroll make", 1'b0);
      send_frame(SC_BREAK, 1'b0);
      send_frame(SC_SCROLL, 1'b0);
      check_status("scroll break", 1'b0);

      idx   = int'($urandom % NUM_KEYS);
      other = (idx + 1 + int'($urandom % (NUM_KEYS - 1))) % NUM_KEYS;
      send_frame(KEY_CODES[idx], 1'b0);
      exp_keys[idx] = 1'b1;
      exp_code      = KEY_CODES[idx];
      send_frame(KEY_CODES[other], 1'b1);
      check_status("parity error", 1'b1);
      check_keys("parity error keys");
      apb_write(8'h04, 32'h4, err);
      check_status("error clear", 1'b0);

      apb_write(8'h00, 32'h0, err);
      send_frame(KEY_CODES[other], 1'b0);
      send_frame(SC_CAPS, 1'b0);
      check_keys("disabled keys");
      check_status("disabled status", 1'b0);
      apb_write(8'h00, 32'h2, err);
      exp_keys = '0;
      check_keys("clear keys");
      check_status("clear keeps toggles", 1'b0);
      apb_write(8'h00, 32'h1, err);
      send_frame(KEY_CODES[other], 1'b0);
      exp_keys[other] = 1'b1;
      exp_code        = KEY_CODES[other];

      apb_write(8'h10, 32'h4000, err);
      ones = 0;
      repeat (1024) begin
         @(negedge clk);
         ones += int'(audio);
      end
      assert (ones >= 255 && ones <= 257) else begin
         $display("CHECK FAILED audio density: expected 256 +/- 1, actual %0d", ones);
         errors++;
      end
      apb_write(8'h10, 32'h0, err);
      repeat (2) @(negedge clk);
      ones = 0;
      repeat (256) begin
         @(negedge clk);
         ones += int'(audio);
      end
      check_value("audio silent", 32'h0, ones);

      apb_write(8'h14, 32'hFFFF_FFFF, err);
      check_value("unmapped write pslverr", 32'h1, {31'h0, err});
      apb_read(8'h14, rd, err);
      check_value("unmapped read pslverr", 32'h1, {31'h0, err});
      check_value("unmapped read data", 32'h0, rd);
      read_check("ctrl unchanged", 8'h00, 32'h1);
      read_check("audio unchanged", 8'h10, 32'h0);
      check_status("status unchanged", 1'b0);
      check_keys("keys unchanged");

      repeat (4) @(negedge clk);
      $display("Errors: %0d failed checks, %0d failed assertions", errors,
               mega99_io_top_i.io_regs_i.props_i.fail_cnt);
      if (errors == 0 && mega99_io_top_i.io_regs_i.props_i.fail_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYC) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYC);
      $display("Some tests failed");
      $finish;
   end

endmodule

//--- build.f
hw/mega99_kbd_pkg.sv
hw/mega99_regs_pkg.sv
hw/ps2_receiver.sv
hw/keyboard_matrix.sv
hw/sigma_delta_dac.sv
hw/io_regs.sv
hw/mega99_io_top.sv
testbench/mega99_io_props.sv
testbench/mega99_io_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module mega99_io_tb \
   || { echo "Build failed"; exit 1; }
./obj_dir/Vmega99_io_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -qx "All tests passed" sim.log && echo "Simulation PASS" && exit 0 \
   || { echo "Simulation FAIL"; exit 1; }
